// ==== bench/intExecUnitTb.sv ====
module intExecUnitTb;
    import rvExecPkg::*;

    localparam int directedSlots = 80;   // Upper bound on directed issue cycles
    localparam int randomSlots   = 400;  // Random stream, gaps included
    localparam int drainSlots    = 4;    // Lets the pipe empty
    localparam int timeoutCycles = directedSlots + randomSlots + 50;

    logic        clk        = 1'b0;
    logic        arstN      = 1'b0;
    logic [31:0] instr      = 32'h0;
    logic        instrValid = 1'b0;
    logic        illegal;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    logic        expLegal   = 1'b0;  // Legality of the word now on instr
    logic [1:0]  legalPipe  = 2'b00;  // Legal strobes of the last two cycles
    logic [31:0] lfsrState  = 32'h22f2;
    logic [31:0] refRegs [32];  // Model copy of the register file
    logic [4:0]  expRd [$];
    logic [31:0] expData [$];
    int          cycleCount = 0;

    intExecUnit intExecUnit_i (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .instrValid (instrValid),
        .illegal    (illegal),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData)
    );

    always #5 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            failRun($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        lsb;
        v = 32'h0;
        for (int i = 0; i < n; i++)
        begin
            lsb       = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (lsb)
                lfsrState = lfsrState ^ 32'h80200003;  // Maximal length taps
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opcOp};
    endfunction

    function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opcOpImm};
    endfunction

    // Expected legality, destination and result of one word
    function automatic void refExec(input logic [31:0] w, output logic legal,
                                    output logic [4:0] rdOut, output logic [31:0] result);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        alt;
        opc    = w[6:0];
        f3     = w[14:12];
        f7     = w[31:25];
        rdOut  = w[11:7];
        a      = refRegs[w[19:15]];
        b      = 32'h0;
        legal  = 1'b1;
        result = 32'h0;
        if (opc == opcOp)
        begin
            b = refRegs[w[24:20]];
            if (f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
                legal = 1'b0;  // Only SUB and SRA take the alt form
        end
        else if (opc == opcOpImm)
        begin
            b = {{20{w[31]}}, w[31:20]};
            if (f3 == 3'd1 && f7 != 7'h00)
                legal = 1'b0;
            if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)
                legal = 1'b0;
        end
        else
        begin
            legal = 1'b0;
        end
        alt = w[30] && (opc == opcOp || f3 == 3'd5);  // ADDI never subtracts
        sh  = b[4:0];
        case (f3)
            3'd0: result = alt ? a - b : a + b;
            3'd1: result = a << sh;
            3'd2: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: result = (a < b) ? 32'd1 : 32'd0;
            3'd4: result = a ^ b;
            3'd5: result = (a >> sh) | ((alt && a[31]) ? ~(32'hFFFFFFFF >> sh) : 32'h0);
            3'd6: result = a | b;
            3'd7: result = a & b;
        endcase
    endfunction

    // Mostly legal words with registers x0 to x7
    function automatic logic [31:0] randomAluWord();
        logic        isImm;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] word;
        isImm = 1'(randBits(1));
        f3    = 3'(randBits(3));
        alt   = 1'(randBits(1));
        rd    = {2'b00, 3'(randBits(3))};
        rs1   = {2'b00, 3'(randBits(3))};
        rs2   = {2'b00, 3'(randBits(3))};
        imm   = 12'(randBits(12));
        if (!isImm)
        begin
            word = encodeR((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
        end
        else
        begin
            if (f3 == 3'd1)
                imm[11:5] = 7'h00;
            if (f3 == 3'd5)
                imm[11:5] = alt ? 7'h20 : 7'h00;  // SRAI or SRLI
            word = encodeI(imm, rs1, f3, rd);
        end
        if (randBits(4) == 32'd0)
            word = randBits(32);  // Occasional raw word, often illegal
        return word;
    endfunction

    task automatic issueWord(input logic [31:0] w);
        logic        legal;
        logic [4:0]  rdOut;
        logic [31:0] res;
        @(posedge clk);
        refExec(w, legal, rdOut, res);
        instr      <= w;
        instrValid <= 1'b1;
        expLegal   <= legal;
        if (legal)
        begin
            expRd.push_back(rdOut);
            expData.push_back(res);
            if (rdOut != 5'd0)
                refRegs[rdOut] = res;  // Program order update
        end
    endtask

    task automatic idleSlot();
        @(posedge clk);
        instr      <= randBits(32);  // Junk while invalid
        instrValid <= 1'b0;
        expLegal   <= 1'b0;
    endtask

    // Compare on the falling edge, away from DUT updates
    always @(negedge clk)
    begin
        if (arstN)
        begin
            checkValue("illegal", 32'(illegal), 32'(instrValid & ~expLegal));
            checkValue("wbValid", 32'(wbValid), 32'(legalPipe[1]));  // Two cycles after issue
            if (wbValid)
            begin
                if (expRd.size() == 0)
                    failRun("Writeback seen with no instruction outstanding");
                else
                begin
                    checkValue("wbRd", 32'(wbRd), 32'(expRd.pop_front()));
                    checkValue("wbData", wbData, expData.pop_front());
                end
            end
            legalPipe = {legalPipe[0], instrValid & expLegal};
        end
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > timeoutCycles)
            failRun("Run did not finish within its cycle limit");
    end

    initial
    begin
        for (int i = 0; i < 32; i++)
            refRegs[i] = 32'h0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        repeat (4) idleSlot();  // No writeback before the first strobe

        issueWord(encodeI(12'hFFB, 5'd0, 3'd0, 5'd1));  // x1 = -5
        issueWord(encodeI(12'h003, 5'd0, 3'd0, 5'd2));  // x2 = 3
        issueWord(encodeI(12'h800, 5'd0, 3'd0, 5'd3));  // x3 = -2048
        issueWord(encodeI(12'h7F1, 5'd0, 3'd0, 5'd4));
        for (int f = 0; f < 8; f++)
            issueWord(encodeR(7'h00, 5'd2, 5'd1, f[2:0], 5'd5));
        issueWord(encodeR(7'h20, 5'd2, 5'd1, 3'd0, 5'd6));  // SUB
        issueWord(encodeR(7'h20, 5'd2, 5'd1, 3'd5, 5'd7));  // SRA of a negative value
        issueWord(encodeR(7'h00, 5'd1, 5'd2, 3'd2, 5'd5));  // 3 < -5 signed
        issueWord(encodeR(7'h00, 5'd1, 5'd2, 3'd3, 5'd5));  // Same pair unsigned
        for (int f = 0; f < 8; f++)
        begin
            if (f == 1 || f == 5)
                issueWord(encodeI({7'h00, 5'd3}, 5'd1, f[2:0], 5'd6));  // SLLI SRLI
            else
                issueWord(encodeI(12'hFFE, 5'd1, f[2:0], 5'd6));
        end
        issueWord(encodeI({7'h20, 5'd3}, 5'd1, 3'd5, 5'd7));  // SRAI
        issueWord(encodeI(12'h7FF, 5'd3, 3'd3, 5'd7));  // SLTIU
        issueWord(encodeI(12'h001, 5'd1, 3'd2, 5'd7));  // SLTI

        // Producer then consumer at distance 1, 2 and 3
        for (int d = 1; d <= 3; d++)
        begin
            issueWord(encodeI(12'(17 + d), 5'd0, 3'd0, 5'd6));
            repeat (d - 1) issueWord(encodeI(12'h05A, 5'd4, 3'd0, 5'd0));  // Filler to x0
            issueWord(encodeR(7'h00, 5'd6, 5'd6, 3'd0, 5'd7));
            issueWord(encodeR(7'h00, 5'd0, 5'd7, 3'd0, 5'd5));
        end
        repeat (4) issueWord(encodeI(12'h001, 5'd5, 3'd0, 5'd5));  // Tight chain on x5
        issueWord(encodeI(12'h123, 5'd4, 3'd0, 5'd0));  // Nonzero result to x0
        issueWord(encodeR(7'h00, 5'd0, 5'd0, 3'd0, 5'd6));  // x0 still reads zero

        issueWord(32'h0000006F);  // Jump opcode
        issueWord(encodeR(7'h01, 5'd2, 5'd1, 3'd0, 5'd5));  // Multiply funct7
        issueWord(encodeR(7'h20, 5'd2, 5'd1, 3'd4, 5'd5));
        issueWord(encodeI({7'h20, 5'd2}, 5'd1, 3'd1, 5'd5));  // SLLI with alt bit
        issueWord(encodeI({7'h10, 5'd2}, 5'd1, 3'd5, 5'd5));
        issueWord(encodeR(7'h00, 5'd5, 5'd5, 3'd0, 5'd6));
        repeat (2) idleSlot();

        for (int n = 0; n < randomSlots; n++)
        begin
            if (randBits(2) == 32'd0)
                idleSlot();
            else
                issueWord(randomAluWord());
        end
        repeat (drainSlots) idleSlot();
        @(posedge clk);

        if (expRd.size() != 0)
            failRun("Instructions issued but never written back");
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== files.f ====
hw/rvExecPkg.sv
hw/aluOpDecoder.sv
hw/regFile.sv
hw/operandForward.sv
hw/alu.sv
hw/intExecUnit.sv
bench/intExecUnitTb.sv

// ==== hw/alu.sv ====
module alu (
    input  logic [rvExecPkg::xLen-1:0]   aluIn1,
    input  logic [rvExecPkg::xLen-1:0]   aluIn2,
    input  logic [rvExecPkg::aluOpW-1:0] aluOp,
    input  logic                         valid,
    output logic [rvExecPkg::xLen-1:0]   aluOut
);
    import rvExecPkg::*;

    logic [shamtW-1:0] shamt;  // Low bits of second operand
    logic              opKnown;
    logic              ltSigned;
    logic              ltUnsigned;

    assign shamt      = aluIn2[shamtW-1:0];
    assign ltSigned   = $signed(aluIn1) < $signed(aluIn2);
    assign ltUnsigned = aluIn1 < aluIn2;

    always_comb
    begin
        opKnown = 1'b1;
        case (aluOp)
            aluAdd:  aluOut = aluIn1 + aluIn2;
            aluSub:  aluOut = aluIn1 - aluIn2;
            aluSll:  aluOut = aluIn1 << shamt;
            aluSlt:  aluOut = {{(xLen - 1){1'b0}}, ltSigned};    // SLT and SLTI
            aluSltu: aluOut = {{(xLen - 1){1'b0}}, ltUnsigned};  // SLTU and SLTIU
            aluXor:  aluOut = aluIn1 ^ aluIn2;
            aluSrl:  aluOut = aluIn1 >> shamt;                   // Zero fill
            aluSra:  aluOut = $unsigned($signed(aluIn1) >>> shamt);  // Sign fill
            aluOr:   aluOut = aluIn1 | aluIn2;
            aluAnd:  aluOut = aluIn1 & aluIn2;
            default:
            begin
                aluOut  = '0;
                opKnown = 1'b0;  // Encoding outside the set
            end
        endcase
    end

    // Issued operations are always in the decoded set
    always_comb
    begin
        if (valid)
        begin
            opLegal: assert (opKnown)
            else
                $error("alu: undefined operation %h", aluOp);
        end
    end

endmodule

// ==== hw/aluOpDecoder.sv ====
module aluOpDecoder (
    input  logic [31:0]                    instr,
    output logic [rvExecPkg::regAddrW-1:0] rs1,
    output logic [rvExecPkg::regAddrW-1:0] rs2,
    output logic [rvExecPkg::regAddrW-1:0] rd,
    output logic [rvExecPkg::xLen-1:0]     imm,
    output logic                           useImm,
    output logic [rvExecPkg::aluOpW-1:0]   aluOp,
    output logic                           illegal
);
    import rvExecPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;  // Upper immediate bits on OP-IMM

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rd  = instr[11:7];   // Destination
    assign rs1 = instr[19:15];  // First source
    assign rs2 = instr[24:20];  // Ignored downstream on OP-IMM

    // I-type immediate, sign extended from bit 31
    assign imm = {{(xLen - 12){instr[31]}}, instr[31:20]};

    always_comb
    begin
        useImm  = 1'b0;
        aluOp   = aluAdd;  // Harmless default
        illegal = 1'b0;
        case (opcode)
            opcOp:
            begin
                if (funct7 == funct7Base)
                    aluOp = {1'b0, funct3};  // Plain function
                else if (funct7 == funct7Alt && (funct3 == f3AddSub || funct3 == f3Sr))
                    aluOp = {1'b1, funct3};  // SUB or SRA
                else
                    illegal = 1'b1;  // Unknown funct7 combo
            end
            opcOpImm:
            begin
                useImm = 1'b1;
                if (funct3 == f3Sll)
                begin
                    aluOp = aluSll;
                    if (funct7 != funct7Base)
                        illegal = 1'b1;  // SLLI upper bits must be zero
                end
                else if (funct3 == f3Sr)
                begin
                    if (funct7 == funct7Base)
                        aluOp = aluSrl;
                    else if (funct7 == funct7Alt)
                        aluOp = aluSra;
                    else
                        illegal = 1'b1;  // Bad SRLI or SRAI field
                end
                else
                begin
                    aluOp = {1'b0, funct3};  // No alternate form here
                end
            end
            default:
            begin
                illegal = 1'b1;  // Not an ALU group
            end
        endcase
    end

endmodule

// ==== hw/intExecUnit.sv ====
module intExecUnit (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [31:0]                    instr,
    input  logic                           instrValid,
    output logic                           illegal,
    output logic                           wbValid,
    output logic [rvExecPkg::regAddrW-1:0] wbRd,
    output logic [rvExecPkg::xLen-1:0]     wbData
);
    import rvExecPkg::*;

    // Issue stage decode
    logic [regAddrW-1:0] decRs1;
    logic [regAddrW-1:0] decRs2;
    logic [regAddrW-1:0] decRd;
    logic [xLen-1:0]     decImm;
    logic                decUseImm;
    logic [aluOpW-1:0]   decAluOp;
    logic                decIllegal;
    logic                issueValid;  // Legal strobe

    // Operand resolution
    logic [xLen-1:0] rfData1;
    logic [xLen-1:0] rfData2;
    logic [xLen-1:0] fwdA;
    logic [xLen-1:0] fwdB;
    logic [xLen-1:0] opB;  // Immediate or rs2

    // Issue register
    logic                exValid;
    logic [xLen-1:0]     exOpA;
    logic [xLen-1:0]     exOpB;
    logic [aluOpW-1:0]   exAluOp;
    logic [regAddrW-1:0] exRd;

    logic [xLen-1:0] aluResult;  // Execute stage output

    aluOpDecoder decoder_i (
        .instr   (instr),
        .rs1     (decRs1),
        .rs2     (decRs2),
        .rd      (decRd),
        .imm     (decImm),
        .useImm  (decUseImm),
        .aluOp   (decAluOp),
        .illegal (decIllegal)
    );

    regFile regFile_i (
        .clk    (clk),
        .arstN  (arstN),
        .raddr1 (decRs1),
        .raddr2 (decRs2),
        .rdata1 (rfData1),
        .rdata2 (rfData2),
        .we     (wbValid),  // Writeback stage commits
        .waddr  (wbRd),
        .wdata  (wbData)
    );

    operandForward fwdA_i (
        .rs       (decRs1),
        .rfData   (rfData1),
        .exValid  (exValid),
        .exRd     (exRd),
        .exResult (aluResult),
        .wbValid  (wbValid),
        .wbRd     (wbRd),
        .wbData   (wbData),
        .operand  (fwdA)
    );

    operandForward fwdB_i (
        .rs       (decRs2),
        .rfData   (rfData2),
        .exValid  (exValid),
        .exRd     (exRd),
        .exResult (aluResult),
        .wbValid  (wbValid),
        .wbRd     (wbRd),
        .wbData   (wbData),
        .operand  (fwdB)
    );

    assign issueValid = instrValid & ~decIllegal;
    assign illegal    = instrValid & decIllegal;  // Same cycle as the strobe
    assign opB        = decUseImm ? decImm : fwdB;

    alu alu_i (
        .aluIn1 (exOpA),
        .aluIn2 (exOpB),
        .aluOp  (exAluOp),
        .valid  (exValid),
        .aluOut (aluResult)
    );

    // Stage valid bits
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            exValid <= 1'b0;
            wbValid <= 1'b0;
        end
        else
        begin
            exValid <= issueValid;
            wbValid <= exValid;  // Two cycles after issue
        end
    end

    // Stage payload
    always_ff @(posedge clk)
    begin
        exOpA   <= fwdA;
        exOpB   <= opB;
        exAluOp <= decAluOp;
        exRd    <= decRd;
        wbRd    <= exRd;
        wbData  <= aluResult;
    end

    // Every writeback traces back to a legal strobe
    wbFromIssue: assert property (
        @(posedge clk) disable iff (!arstN)
        wbValid |-> $past(issueValid, 2)
    )
    else
        $error("intExecUnit: writeback without matching issue");

endmodule

// ==== hw/operandForward.sv ====
module operandForward (
    input  logic [rvExecPkg::regAddrW-1:0] rs,
    input  logic [rvExecPkg::xLen-1:0]     rfData,
    input  logic                           exValid,
    input  logic [rvExecPkg::regAddrW-1:0] exRd,
    input  logic [rvExecPkg::xLen-1:0]     exResult,
    input  logic                           wbValid,
    input  logic [rvExecPkg::regAddrW-1:0] wbRd,
    input  logic [rvExecPkg::xLen-1:0]     wbData,
    output logic [rvExecPkg::xLen-1:0]     operand
);
    import rvExecPkg::*;

    logic rsLive;  // Source is not x0
    logic hitEx;
    logic hitWb;

    assign rsLive = (rs != '0);
    assign hitEx  = rsLive && exValid && (exRd == rs);  // Result one stage ahead
    assign hitWb  = rsLive && wbValid && (wbRd == rs);  // Write not yet in file

    // Youngest producer wins
    always_comb
    begin
        if (hitEx)
            operand = exResult;
        else if (hitWb)
            operand = wbData;
        else
            operand = rfData;  // Committed value
    end

endmodule

// ==== hw/regFile.sv ====
module regFile (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [rvExecPkg::regAddrW-1:0] raddr1,
    input  logic [rvExecPkg::regAddrW-1:0] raddr2,
    output logic [rvExecPkg::xLen-1:0]     rdata1,
    output logic [rvExecPkg::xLen-1:0]     rdata2,
    input  logic                           we,
    input  logic [rvExecPkg::regAddrW-1:0] waddr,
    input  logic [rvExecPkg::xLen-1:0]     wdata
);
    import rvExecPkg::*;

    logic [xLen-1:0] regs [regCount];  // x0 is never written

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;  // Everything reads zero after reset
        end
        else if (we && waddr != '0)
        begin
            regs[waddr] <= wdata;  // Visible on the next cycle
        end
    end

    // Asynchronous reads
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // A write must always target a defined register
    wAddrKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        we |-> !$isunknown(waddr)
    )
    else
        $error("regFile: write with unknown address");

endmodule

// ==== hw/rvExecPkg.sv ====
package rvExecPkg;

    localparam int xLen     = 32;  // Data path width
    localparam int regAddrW = 5;   // Register index width
    localparam int regCount = 32;  // Architectural registers
    localparam int shamtW   = 5;   // Shift amount bits
    localparam int aluOpW   = 4;   // Alt bit plus funct3

    // Major opcodes of the two accepted groups
    localparam logic [6:0] opcOp    = 7'b0110011;  // Register-register
    localparam logic [6:0] opcOpImm = 7'b0010011;  // Register-immediate

    localparam logic [6:0] funct7Base = 7'b0000000;  // Normal function
    localparam logic [6:0] funct7Alt  = 7'b0100000;  // SUB and SRA

    localparam logic [2:0] f3AddSub = 3'b000;  // ADD SUB ADDI
    localparam logic [2:0] f3Sll    = 3'b001;  // Left shift
    localparam logic [2:0] f3Slt    = 3'b010;  // Signed compare
    localparam logic [2:0] f3Sltu   = 3'b011;  // Unsigned compare
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Sr     = 3'b101;  // SRL and SRA share it
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // ALU operation is {alt, funct3}
    localparam logic [aluOpW-1:0] aluAdd  = {1'b0, f3AddSub};
    localparam logic [aluOpW-1:0] aluSub  = {1'b1, f3AddSub};
    localparam logic [aluOpW-1:0] aluSll  = {1'b0, f3Sll};
    localparam logic [aluOpW-1:0] aluSlt  = {1'b0, f3Slt};
    localparam logic [aluOpW-1:0] aluSltu = {1'b0, f3Sltu};
    localparam logic [aluOpW-1:0] aluXor  = {1'b0, f3Xor};
    localparam logic [aluOpW-1:0] aluSrl  = {1'b0, f3Sr};
    localparam logic [aluOpW-1:0] aluSra  = {1'b1, f3Sr};  // Arithmetic right
    localparam logic [aluOpW-1:0] aluOr   = {1'b0, f3Or};
    localparam logic [aluOpW-1:0] aluAnd  = {1'b0, f3And};

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the execute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module intExecUnitTb -f files.f -o simv || exit 1

out=$(./obj_dir/simv)
echo "$out"

echo "$out" | grep -q "Simulation finished: PASS" && echo "run.sh: passed" || { echo "run.sh: failed"; exit 1; }
